/* source/histPkg.sv */
`default_nettype none

package histPkg;

    // histogram geometry
    localparam int PIXEL_W      = 2;   // 4 pixels
    localparam int BIN_W        = 4;   // 16 time bins
    localparam int ADDR_W       = PIXEL_W + BIN_W;
    localparam int COUNT_W      = 4;   // saturates at 15

    // frame and flow control
    localparam int FRAME_EVENTS = 32;
    localparam int CREDIT_MAX   = 4;   // buffer depth = sender credits

    typedef logic [PIXEL_W-1:0] pixelT;
    typedef logic [BIN_W-1:0]   binT;
    typedef logic [ADDR_W-1:0]  addrT;  // {pixel, bin}
    typedef logic [COUNT_W-1:0] countT;

    // control phases, in the order a frame walks through them
    typedef enum logic [1:0] {
        ClearS,
        AccumS,
        DrainS,
        ScanS
    } ctrlStateT;

endpackage

`default_nettype wire

/* source/eventBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module eventBuffer import histPkg::*; (
    input  wire        clk,
    input  wire        res,
    input  wire        evValid,
    input  wire pixelT evPixel,
    input  wire binT   evBin,
    input  wire        bufPop,
    output logic       bufValid,
    output pixelT      bufPixel,
    output binT        bufBin,
    output logic       creditReturn
);

    localparam int PTR_W = $clog2(CREDIT_MAX);

    pixelT pixMem [CREDIT_MAX];
    binT   binMem [CREDIT_MAX];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   fill;   // 0 .. CREDIT_MAX

    // entry storage
    always_ff @(posedge clk) begin
        if (evValid) begin
            pixMem[wrPtr] <= evPixel;
            binMem[wrPtr] <= evBin;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (evValid) wrPtr <= wrPtr + 1'b1;  // wraps at depth
            if (bufPop)  rdPtr <= rdPtr + 1'b1;
            fill <= fill + (PTR_W+1)'(evValid) - (PTR_W+1)'(bufPop);
        end
    end

    assign bufValid = (fill != '0);
    assign bufPixel = pixMem[rdPtr];
    assign bufBin   = binMem[rdPtr];

    // one credit back per popped entry in the pop cycle
    assign creditReturn = bufPop;

endmodule

`default_nettype wire

/* source/phaseCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module phaseCounter import histPkg::*; (
    input  wire  clk,
    input  wire  res,
    input  wire  cntClear,
    input  wire  cntStep,
    output addrT cntValue,
    output logic cntLastAddr,
    output logic cntFrameFull
);

    // clear address, event count or scan address depending on phase
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cntValue <= '0;
        end else if (cntClear) begin
            cntValue <= '0;  // phase change wins over a step
        end else if (cntStep) begin
            cntValue <= cntValue + 1'b1;
        end
    end

    // terminal flags
    assign cntLastAddr  = (cntValue == addrT'('1));
    assign cntFrameFull = (cntValue == addrT'(FRAME_EVENTS - 1));

endmodule

`default_nettype wire

/* source/histControl.sv */
`timescale 1ns/1ps
`default_nettype none

module histControl import histPkg::*; (
    input  wire  clk,
    input  wire  res,
    input  wire  bufValid,
    input  wire  cntLastAddr,
    input  wire  cntFrameFull,
    output logic bufPop,
    output logic cntClear,
    output logic cntStep,
    output logic histClear,
    output logic histAccum,
    output logic histScan
);

    ctrlStateT state;
    ctrlStateT nextState;
    logic      drainTick;  // second drain cycle

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= ClearS;
            drainTick <= 1'b0;
        end else begin
            state     <= nextState;
            drainTick <= (state == DrainS) && !drainTick;
        end
    end

    always_comb begin
        nextState = state;
        bufPop    = 1'b0;
        cntClear  = 1'b0;
        cntStep   = 1'b0;
        histClear = 1'b0;
        histAccum = 1'b0;
        histScan  = 1'b0;
        case (state)
            ClearS: begin
                histClear = 1'b1;  // zero one address per cycle
                cntStep   = 1'b1;
                if (cntLastAddr) begin
                    nextState = AccumS;
                    cntClear  = 1'b1;
                end
            end
            AccumS: begin
                bufPop    = bufValid;
                histAccum = bufValid;
                cntStep   = bufValid;
                // last event of the frame has just been popped
                if (bufValid && cntFrameFull) begin
                    nextState = DrainS;
                    cntClear  = 1'b1;
                end
            end
            DrainS: begin
                // let the in-flight read-modify-write land
                if (drainTick) nextState = ScanS;
            end
            ScanS: begin
                histScan = 1'b1;
                cntStep  = 1'b1;
                if (cntLastAddr) begin
                    nextState = ClearS;
                    cntClear  = 1'b1;
                end
            end
            default: nextState = ClearS;
        endcase
    end

endmodule

`default_nettype wire

/* source/histAccumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module histAccumulator import histPkg::*; (
    input  wire        clk,
    input  wire        res,
    input  wire        histClear,
    input  wire        histAccum,
    input  wire        histScan,
    input  wire addrT  clrAddr,
    input  wire pixelT accPixel,
    input  wire binT   accBin,
    output logic       rdValid,
    output addrT       rdAddr,
    output countT      rdCount
);

    countT mem [2**ADDR_W];

    addrT  accAddr;
    addrT  pendAddr;    // address of the event being written back
    logic  pendValid;
    logic  fwdHit;      // pending event follows a write to the same bin
    countT fwdCount;
    countT memQ;        // one-cycle read data
    countT baseCount;
    countT newCount;

    assign accAddr = {accPixel, accBin};

    // old count, or the value written on the cycle the read was missed
    assign baseCount = fwdHit ? fwdCount : memQ;
    assign newCount  = (baseCount == countT'('1)) ? baseCount : baseCount + 1'b1;

    // single read port, scan and accumulate never overlap
    always_ff @(posedge clk) begin
        if (histScan) begin
            memQ <= mem[clrAddr];
        end else if (histAccum) begin
            memQ <= mem[accAddr];
        end
        if (histClear) begin
            mem[clrAddr] <= '0;
        end else if (pendValid) begin
            mem[pendAddr] <= newCount;  // saturating write-back
        end
        pendAddr <= accAddr;
        fwdCount <= newCount;
        rdAddr   <= clrAddr;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pendValid <= 1'b0;
            fwdHit    <= 1'b0;
            rdValid   <= 1'b0;
        end else begin
            pendValid <= histAccum;
            fwdHit    <= histAccum && pendValid && (accAddr == pendAddr);
            rdValid   <= histScan;
        end
    end

    assign rdCount = memQ;

endmodule

`default_nettype wire

/* source/peakFinder.sv */
`timescale 1ns/1ps
`default_nettype none

module peakFinder import histPkg::*; (
    input  wire        clk,
    input  wire        res,
    input  wire        rdValid,
    input  wire addrT  rdAddr,
    input  wire countT rdCount,
    output logic       peakValid,
    output pixelT      peakPixel,
    output binT        peakBin,
    output countT      peakCount
);

    binT   curBin;
    countT maxCount;   // running max for the current pixel
    binT   maxBin;
    logic  better;
    countT nextCount;
    binT   nextBin;

    assign curBin    = rdAddr[BIN_W-1:0];
    // bin 0 restarts the search, strict compare keeps the lowest bin on a tie
    assign better    = (curBin == '0) || (rdCount > maxCount);
    assign nextCount = better ? rdCount : maxCount;
    assign nextBin   = better ? curBin : maxBin;

    always_ff @(posedge clk) begin
        if (rdValid) begin
            maxCount <= nextCount;
            maxBin   <= nextBin;
        end
        if (rdValid && curBin == binT'('1)) begin
            peakPixel <= rdAddr[ADDR_W-1:BIN_W];
            peakBin   <= nextBin;
            peakCount <= nextCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= rdValid && (curBin == binT'('1));  // one pulse per pixel
        end
    end

endmodule

`default_nettype wire

/* source/tofHistTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tofHistTop import histPkg::*; (
    input  wire        clk,
    input  wire        res,
    input  wire        evValid,
    input  wire pixelT evPixel,
    input  wire binT   evBin,
    output logic       creditReturn,
    output logic       peakValid,
    output pixelT      peakPixel,
    output binT        peakBin,
    output countT      peakCount
);

    logic  bufValid;
    pixelT bufPixel;
    binT   bufBin;
    logic  bufPop;
    logic  cntClear;
    logic  cntStep;
    addrT  cntValue;
    logic  cntLastAddr;
    logic  cntFrameFull;
    logic  histClear;
    logic  histAccum;
    logic  histScan;
    logic  rdValid;
    addrT  rdAddr;
    countT rdCount;

    // input FIFO, credits match its depth
    eventBuffer uBuffer (
        .clk(clk), .res(res),
        .evValid(evValid), .evPixel(evPixel), .evBin(evBin),
        .bufPop(bufPop),
        .bufValid(bufValid), .bufPixel(bufPixel), .bufBin(bufBin),
        .creditReturn(creditReturn)
    );

    phaseCounter uCounter (
        .clk(clk), .res(res),
        .cntClear(cntClear), .cntStep(cntStep),
        .cntValue(cntValue), .cntLastAddr(cntLastAddr), .cntFrameFull(cntFrameFull)
    );

    histControl uControl (
        .clk(clk), .res(res),
        .bufValid(bufValid),
        .cntLastAddr(cntLastAddr), .cntFrameFull(cntFrameFull),
        .bufPop(bufPop), .cntClear(cntClear), .cntStep(cntStep),
        .histClear(histClear), .histAccum(histAccum), .histScan(histScan)
    );

    histAccumulator uAccum (
        .clk(clk), .res(res),
        .histClear(histClear), .histAccum(histAccum), .histScan(histScan),
        .clrAddr(cntValue),  // clear and scan address
        .accPixel(bufPixel), .accBin(bufBin),
        .rdValid(rdValid), .rdAddr(rdAddr), .rdCount(rdCount)
    );

    peakFinder uPeak (
        .clk(clk), .res(res),
        .rdValid(rdValid), .rdAddr(rdAddr), .rdCount(rdCount),
        .peakValid(peakValid), .peakPixel(peakPixel),
        .peakBin(peakBin), .peakCount(peakCount)
    );

endmodule

`default_nettype wire

/* dv/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic res
);

    localparam int PERIOD_NS    = 8;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // active low, released just after a rising edge
    initial begin
        res = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        res = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/tofHistTb.sv */
`timescale 1ns/1ps
`default_nettype none

module tofHistTb import histPkg::*; ();

    localparam int SEED       = 65;
    localparam int NFRAMES    = 10;   // 6 random, saturation, 2 with runs, ties
    localparam int NUM_PIXELS = 2**PIXEL_W;
    localparam int NUM_BINS   = 2**BIN_W;
    localparam int SAT_LIMIT  = 2**COUNT_W - 1;
    localparam int NEV        = NFRAMES * FRAME_EVENTS;
    localparam int NPEAKS     = NFRAMES * NUM_PIXELS;
    localparam int WATCHDOG_CYCLES = 2 * NFRAMES * (64 + FRAME_EVENTS * 4 + 70);

    logic  clk;
    logic  res;
    logic  evValid;
    pixelT evPixel;
    binT   evBin;
    logic  creditReturn;
    logic  peakValid;
    pixelT peakPixel;
    binT   peakBin;
    countT peakCount;

    // frame k owns events 32k .. 32k+31 in send order
    pixelT evPixArr [NEV];
    binT   evBinArr [NEV];
    int    gapArr   [NEV];   // idle cycles before the event

    int credits;
    int sentCount;
    int returnCount;
    int occupancy;     // events sent but not yet popped
    int creditStalls;
    int peakIdx;

    tbClock uClock (.clk(clk), .res(res));

    tofHistTop u_dut (
        .clk(clk), .res(res),
        .evValid(evValid), .evPixel(evPixel), .evBin(evBin),
        .creditReturn(creditReturn),
        .peakValid(peakValid), .peakPixel(peakPixel),
        .peakBin(peakBin), .peakCount(peakCount)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            abortRun($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    // expected {bin, count} of one pixel in one frame
    function automatic logic [BIN_W+COUNT_W-1:0] refPeak(input int frame, input int pixel);
        int counts [NUM_BINS];
        int bestBin;
        int bestCount;
        int idx;
        for (int b = 0; b < NUM_BINS; b++) counts[b] = 0;
        for (int e = 0; e < FRAME_EVENTS; e++) begin
            idx = frame * FRAME_EVENTS + e;
            if (int'(evPixArr[idx]) == pixel && counts[evBinArr[idx]] < SAT_LIMIT) begin
                counts[evBinArr[idx]]++;
            end
        end
        bestBin   = 0;
        bestCount = counts[0];
        for (int b = 1; b < NUM_BINS; b++) begin
            if (counts[b] > bestCount) begin  // strict compare so the lowest bin wins a tie
                bestBin   = b;
                bestCount = counts[b];
            end
        end
        return {binT'(bestBin), countT'(bestCount)};
    endfunction

    task automatic setEvent(input int idx, input pixelT pix, input binT bin, input int gap);
        evPixArr[idx] = pix;
        evBinArr[idx] = bin;
        gapArr[idx]   = gap;
    endtask

    task automatic randomFrame(input int frame);
        int gap;
        for (int i = 0; i < FRAME_EVENTS; i++) begin
            gap = ($urandom_range(3, 0) == 0) ? int'($urandom_range(3, 1)) : 0;
            setEvent(frame * FRAME_EVENTS + i, pixelT'($urandom_range(NUM_PIXELS - 1, 0)),
                     binT'($urandom_range(NUM_BINS - 1, 0)), gap);
        end
    endtask

    // all events into one bin to push well past saturation
    task automatic saturationFrame(input int frame);
        for (int i = 0; i < FRAME_EVENTS; i++) begin
            setEvent(frame * FRAME_EVENTS + i, 2'd2, 4'd9, 0);
        end
    endtask

    // back-to-back runs to one address without idle cycles
    task automatic runFrame(input int frame);
        int    i;
        int    runLen;
        pixelT pix;
        binT   bin;
        i = 0;
        while (i < FRAME_EVENTS) begin
            pix    = pixelT'($urandom_range(NUM_PIXELS - 1, 0));
            bin    = binT'($urandom_range(NUM_BINS - 1, 0));
            runLen = int'($urandom_range(5, 2));
            for (int k = 0; k < runLen && i < FRAME_EVENTS; k++) begin
                setEvent(frame * FRAME_EVENTS + i, pix, bin, 0);
                i++;
            end
        end
    endtask

    // higher bin of each tie arrives first and pixel 3 stays empty
    task automatic tieFrame(input int frame);
        int base;
        base = frame * FRAME_EVENTS;
        for (int i = 0; i < FRAME_EVENTS; i++) begin
            if (i < 5)       setEvent(base + i, 2'd1, 4'd7, 0);
            else if (i < 10) setEvent(base + i, 2'd1, 4'd3, 0);
            else if (i < 14) setEvent(base + i, 2'd0, 4'd12, 0);
            else if (i < 18) setEvent(base + i, 2'd0, 4'd2, 0);
            else if (i < 25) setEvent(base + i, 2'd2, 4'd15, 0);
            else             setEvent(base + i, 2'd2, 4'd0, 0);
        end
    endtask

    task automatic buildStimulus();
        for (int f = 0; f < 6; f++) randomFrame(f);
        saturationFrame(6);
        runFrame(7);
        runFrame(8);
        tieFrame(9);
    endtask

    // credit-obeying sender driving 1 ns after the rising edge
    task automatic sendEvents();
        @(posedge clk);
        #1;
        for (int i = 0; i < NEV; i++) begin
            if (gapArr[i] > 0 || credits == 0) evValid = 1'b0;
            repeat (gapArr[i]) begin
                @(posedge clk);
                #1;
            end
            while (credits == 0) begin
                creditStalls++;
                @(posedge clk);
                #1;
            end
            evValid = 1'b1;
            evPixel = evPixArr[i];
            evBin   = evBinArr[i];
            credits--;
            sentCount++;
            @(posedge clk);
            #1;
        end
        evValid = 1'b0;
    endtask

    // credit return and buffer occupancy sampled mid-cycle
    always @(negedge clk) begin
        if (res) begin
            if (creditReturn) begin
                credits++;
                returnCount++;
            end
            occupancy = occupancy + (evValid ? 1 : 0) - (creditReturn ? 1 : 0);
            if (occupancy < 0) begin
                abortRun("creditReturn pulsed without an event in the buffer");
            end
        end
    end

    always @(negedge clk) begin
        logic [BIN_W+COUNT_W-1:0] expected;
        int frame;
        int pixel;
        if (res && peakValid) begin
            if (peakIdx >= NPEAKS) begin
                abortRun("peakValid pulsed after the last frame had been reported");
            end else begin
                frame    = peakIdx / NUM_PIXELS;
                pixel    = peakIdx % NUM_PIXELS;
                expected = refPeak(frame, pixel);
                checkValue($sformatf("peakPixel frame %0d", frame), 32'(peakPixel), 32'(pixel));
                checkValue($sformatf("peakBin frame %0d pixel %0d", frame, pixel),
                           32'(peakBin), 32'(expected[COUNT_W +: BIN_W]));
                checkValue($sformatf("peakCount frame %0d pixel %0d", frame, pixel),
                           32'(peakCount), 32'(expected[COUNT_W-1:0]));
                peakIdx++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abortRun($sformatf("timeout after %0d cycles, peak results stopped arriving %s",
                           WATCHDOG_CYCLES, $sformatf("(%0d of %0d)", peakIdx, NPEAKS)));
    end

    initial begin
        evValid      = 1'b0;
        evPixel      = '0;
        evBin        = '0;
        credits      = CREDIT_MAX;
        sentCount    = 0;
        returnCount  = 0;
        occupancy    = 0;
        creditStalls = 0;
        peakIdx      = 0;
        void'($urandom(SEED));
        buildStimulus();
        wait (res == 1'b1);
        sendEvents();
        wait (peakIdx == NPEAKS);
        checkValue("creditReturn pulse count", 32'(returnCount), 32'(sentCount));
        if (creditStalls == 0) begin
            abortRun("sender never ran out of credits, so back-pressure was not exercised");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* compile.f */
source/histPkg.sv
source/eventBuffer.sv
source/phaseCounter.sv
source/histControl.sv
source/histAccumulator.sv
source/peakFinder.sv
source/tofHistTop.sv
dv/tbClock.sv
dv/tofHistTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tofHistTb
FILELIST  = compile.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJDIR)
